// ==== include/lc3b_defs.svh ====
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

// Datapath sizes.
`define LC3B_WORD_W    16
`define LC3B_NUM_REGS  8

// Fetch starts here after reset.
`define LC3B_RESET_PC  16'h0000

// ##################################################
// Opcodes in ir[15:12].
// ##################################################
`define LC3B_OP_BR     4'b0000
`define LC3B_OP_ADD    4'b0001
`define LC3B_OP_AND    4'b0101
`define LC3B_OP_LDR    4'b0110
`define LC3B_OP_STR    4'b0111
`define LC3B_OP_NOT    4'b1001

`endif

// ==== design/lc3b_pkg.sv ====
`default_nettype none

`include "lc3b_defs.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_alu_op;

    // All zero means no side effects at all.
    typedef struct packed {
        lc3b_alu_op alu_op;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
        logic       use_imm;
        logic [2:0] nzp;
    } lc3b_control_word;

    // ##################################################
    // Barrier payloads with valid always first.
    // ##################################################
    typedef struct packed {
        logic     valid;
        lc3b_word pc_plus2;
        lc3b_word ir;
    } if_id_t;

    typedef struct packed {
        logic             valid;
        lc3b_control_word control;
        lc3b_word         ir;
        lc3b_word         pc_plus2;
        lc3b_word         sr1_data;
        lc3b_word         sr2_data;
        lc3b_reg          sr1;
        lc3b_reg          sr2;
        lc3b_reg          dest;
    } id_ex_t;

    typedef struct packed {
        logic             valid;
        lc3b_control_word control;
        lc3b_reg          dest;
        lc3b_word         alu;
        lc3b_word         pcn;
        lc3b_word         store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        lc3b_reg  dest;
        lc3b_word result;
    } mem_wb_t;

    typedef struct packed {
        logic     valid;
        lc3b_reg  dest;
        lc3b_word data;
    } retire_t;

    // Held high by the CPU until the ack pulse.
    typedef struct packed {
        logic     req;
        logic     we;
        lc3b_word addr;
        lc3b_word wdata;
    } dmem_req_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_from_ex_mem,
        fwd_from_mem_wb
    } fwd_sel_t;

endpackage

`default_nettype wire

// ==== design/pipe_barrier.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_barrier #(
    parameter type payload_t = logic [0:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Flush wins over stall so a redirect always clears wrong-path work.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== design/stage_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_defs.svh"

module stage_fetch (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               stall,
    input  logic               redirect,
    input  lc3b_pkg::lc3b_word redirect_pc,
    output lc3b_pkg::lc3b_word imem_addr,
    input  lc3b_pkg::lc3b_word imem_rdata,
    output lc3b_pkg::if_id_t   fetched
);

    lc3b_pkg::lc3b_word pc;
    lc3b_pkg::lc3b_word pc_plus2;
    lc3b_pkg::lc3b_word pc_next;

    assign pc_plus2 = pc + lc3b_pkg::lc3b_word'(2);

    // Redirect from MEM beats any stall.
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc_plus2;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `LC3B_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // Instruction memory answers in the same cycle.
    assign imem_addr        = pc;
    assign fetched.valid    = 1'b1;
    assign fetched.pc_plus2 = pc_plus2;
    assign fetched.ir       = imem_rdata;

endmodule

`default_nettype wire

// ==== design/stage_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_defs.svh"

module stage_decode (
    input  logic              clk,
    input  logic              arst_n,
    input  lc3b_pkg::if_id_t  in_if,
    input  lc3b_pkg::mem_wb_t wb,
    output lc3b_pkg::id_ex_t  decoded
);

    lc3b_pkg::lc3b_word         regs [`LC3B_NUM_REGS];
    lc3b_pkg::lc3b_control_word ctrl;
    logic [3:0]                 opcode;
    lc3b_pkg::lc3b_reg          sr1;
    lc3b_pkg::lc3b_reg          sr2;

    assign opcode = in_if.ir[15:12];
    assign sr1    = in_if.ir[8:6];
    // STR carries its source register where the others carry dest.
    assign sr2    = (opcode == `LC3B_OP_STR) ? in_if.ir[11:9] : in_if.ir[2:0];

    // ##################################################
    // Control word.
    // ##################################################
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = lc3b_pkg::alu_pass;
        case (opcode)
            `LC3B_OP_ADD: begin
                ctrl.alu_op    = lc3b_pkg::alu_add;
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = in_if.ir[5];
            end
            `LC3B_OP_AND: begin
                ctrl.alu_op    = lc3b_pkg::alu_and;
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = in_if.ir[5];
            end
            `LC3B_OP_NOT: begin
                ctrl.alu_op    = lc3b_pkg::alu_not;
                ctrl.reg_write = 1'b1;
            end
            `LC3B_OP_LDR: begin
                ctrl.alu_op    = lc3b_pkg::alu_add;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            `LC3B_OP_STR: begin
                ctrl.alu_op    = lc3b_pkg::alu_add;
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            `LC3B_OP_BR: begin
                ctrl.is_branch = 1'b1;
                ctrl.nzp       = in_if.ir[11:9];
            end
            default: begin
            end
        endcase
    end

    // ##################################################
    // Register file with write-through read.
    // ##################################################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.reg_write) begin
            regs[wb.dest] <= wb.result;
        end
    end

    function automatic lc3b_pkg::lc3b_word read_port(input lc3b_pkg::lc3b_reg idx);
        if (wb.valid && wb.reg_write && wb.dest == idx) begin
            return wb.result;
        end
        return regs[idx];
    endfunction

    assign decoded.valid    = in_if.valid;
    assign decoded.control  = ctrl;
    assign decoded.ir       = in_if.ir;
    assign decoded.pc_plus2 = in_if.pc_plus2;
    assign decoded.sr1_data = read_port(sr1);
    assign decoded.sr2_data = read_port(sr2);
    assign decoded.sr1      = sr1;
    assign decoded.sr2      = sr2;
    assign decoded.dest     = in_if.ir[11:9];

endmodule

`default_nettype wire

// ==== design/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  lc3b_pkg::id_ex_t   in_id,
    input  lc3b_pkg::id_ex_t   in_ex,
    input  lc3b_pkg::ex_mem_t  in_mem,
    input  lc3b_pkg::mem_wb_t  in_wb,
    input  logic               mem_busy,
    input  logic               branch_taken,
    output logic               stall_fetch,
    output logic               stall_if_id,
    output logic               stall_id_ex,
    output logic               stall_ex_mem,
    output logic               stall_mem_wb,
    output logic               flush_if_id,
    output logic               flush_id_ex,
    output logic               flush_ex_mem,
    output logic               flush_mem_wb,
    output lc3b_pkg::fwd_sel_t fwd_a,
    output lc3b_pkg::fwd_sel_t fwd_b
);

    logic id_uses_sr1;
    logic id_uses_sr2;
    logic load_use;

    // Only real consumers trigger the bubble.
    assign id_uses_sr1 = in_id.control.reg_write | in_id.control.mem_write;
    assign id_uses_sr2 = in_id.control.mem_write
                       | (in_id.control.reg_write & ~in_id.control.use_imm
                          & (in_id.control.alu_op != lc3b_pkg::alu_not));

    assign load_use = in_id.valid && in_ex.valid && in_ex.control.mem_read
                   && ((id_uses_sr1 && in_ex.dest == in_id.sr1)
                    || (id_uses_sr2 && in_ex.dest == in_id.sr2));

    // ##################################################
    // Stalls and flushes.
    // ##################################################
    assign stall_fetch  = mem_busy | load_use;
    assign stall_if_id  = mem_busy | load_use;
    assign stall_id_ex  = mem_busy;
    assign stall_ex_mem = mem_busy;
    assign stall_mem_wb = 1'b0;

    // Three younger instructions die on a taken branch.
    assign flush_if_id  = branch_taken;
    assign flush_id_ex  = branch_taken | (load_use & ~mem_busy);
    assign flush_ex_mem = branch_taken;
    // Bubbles behind a waiting access keep retire one-shot.
    assign flush_mem_wb = mem_busy;

    // EX/MEM is newer, so it wins. Loads there are covered by load_use.
    function automatic lc3b_pkg::fwd_sel_t pick(input lc3b_pkg::lc3b_reg src);
        if (in_mem.valid && in_mem.control.reg_write && !in_mem.control.mem_read
                && in_mem.dest == src) begin
            return lc3b_pkg::fwd_from_ex_mem;
        end
        if (in_wb.valid && in_wb.reg_write && in_wb.dest == src) begin
            return lc3b_pkg::fwd_from_mem_wb;
        end
        return lc3b_pkg::fwd_none;
    endfunction

    assign fwd_a = pick(in_ex.sr1);
    assign fwd_b = pick(in_ex.sr2);

endmodule

`default_nettype wire

// ==== design/stage_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_execute (
    input  lc3b_pkg::id_ex_t   in_ex,
    input  lc3b_pkg::fwd_sel_t fwd_a,
    input  lc3b_pkg::fwd_sel_t fwd_b,
    input  lc3b_pkg::lc3b_word fwd_ex_mem,
    input  lc3b_pkg::lc3b_word fwd_mem_wb,
    output lc3b_pkg::ex_mem_t  out_ex
);

    lc3b_pkg::lc3b_word op_a;
    lc3b_pkg::lc3b_word reg_b;
    lc3b_pkg::lc3b_word imm;
    lc3b_pkg::lc3b_word op_b;
    lc3b_pkg::lc3b_word alu;

    function automatic lc3b_pkg::lc3b_word fwd_mux(input lc3b_pkg::fwd_sel_t sel,
                                                   input lc3b_pkg::lc3b_word reg_val);
        case (sel)
            lc3b_pkg::fwd_from_ex_mem: return fwd_ex_mem;
            lc3b_pkg::fwd_from_mem_wb: return fwd_mem_wb;
            default:                   return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, in_ex.sr1_data);
    assign reg_b = fwd_mux(fwd_b, in_ex.sr2_data);

    // Memory offsets count words, ALU immediates are imm5.
    assign imm = (in_ex.control.mem_read || in_ex.control.mem_write)
               ? lc3b_pkg::lc3b_word'(signed'(in_ex.ir[5:0])) << 1
               : lc3b_pkg::lc3b_word'(signed'(in_ex.ir[4:0]));
    assign op_b = in_ex.control.use_imm ? imm : reg_b;

    always_comb begin
        case (in_ex.control.alu_op)
            lc3b_pkg::alu_add: alu = op_a + op_b;
            lc3b_pkg::alu_and: alu = op_a & op_b;
            lc3b_pkg::alu_not: alu = ~op_a;
            default:           alu = op_b;
        endcase
    end

    assign out_ex.valid      = in_ex.valid;
    assign out_ex.control    = in_ex.control;
    assign out_ex.dest       = in_ex.dest;
    assign out_ex.alu        = alu;
    // Branch target from offset9 in words.
    assign out_ex.pcn        = in_ex.pc_plus2
                             + (lc3b_pkg::lc3b_word'(signed'(in_ex.ir[8:0])) << 1);
    assign out_ex.store_data = reg_b;

endmodule

`default_nettype wire

// ==== design/stage_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_memory (
    input  logic                clk,
    input  logic                arst_n,
    input  lc3b_pkg::ex_mem_t   in_mem,
    output lc3b_pkg::dmem_req_t dmem_req,
    input  logic                dmem_ack,
    input  lc3b_pkg::lc3b_word  dmem_rdata,
    output logic                busy,
    output logic                branch_taken,
    output lc3b_pkg::lc3b_word  branch_pc,
    output lc3b_pkg::mem_wb_t   out_wb
);

    logic               mem_op;
    logic [2:0]         cc;
    lc3b_pkg::lc3b_word result;

    assign mem_op = in_mem.valid & (in_mem.control.mem_read | in_mem.control.mem_write);
    assign busy   = mem_op & ~dmem_ack;

    // Level request held while EX/MEM is frozen.
    assign dmem_req.req   = mem_op;
    assign dmem_req.we    = mem_op & in_mem.control.mem_write;
    assign dmem_req.addr  = in_mem.alu;
    assign dmem_req.wdata = in_mem.store_data;

    assign result = in_mem.control.mem_read ? dmem_rdata : in_mem.alu;

    // ##################################################
    // Condition codes from the last write leaving MEM.
    // ##################################################
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cc <= 3'b010;
        end else if (in_mem.valid && in_mem.control.reg_write && !busy) begin
            if (result[$bits(result)-1]) begin
                cc <= 3'b100;
            end else if (result == '0) begin
                cc <= 3'b010;
            end else begin
                cc <= 3'b001;
            end
        end
    end

    assign branch_taken = in_mem.valid & in_mem.control.is_branch
                        & |(in_mem.control.nzp & cc);
    assign branch_pc    = in_mem.pcn;

    assign out_wb.valid     = in_mem.valid;
    assign out_wb.reg_write = in_mem.control.reg_write;
    assign out_wb.dest      = in_mem.dest;
    assign out_wb.result    = result;

endmodule

`default_nettype wire

// ==== design/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  logic                clk,
    input  logic                arst_n,
    output lc3b_pkg::lc3b_word  imem_addr,
    input  lc3b_pkg::lc3b_word  imem_rdata,
    output lc3b_pkg::dmem_req_t dmem_req,
    input  logic                dmem_ack,
    input  lc3b_pkg::lc3b_word  dmem_rdata,
    output lc3b_pkg::retire_t   retire
);

    lc3b_pkg::if_id_t   fetched;
    lc3b_pkg::if_id_t   if_id_q;
    lc3b_pkg::id_ex_t   decoded;
    lc3b_pkg::id_ex_t   id_ex_held;
    lc3b_pkg::id_ex_t   id_ex_d;
    lc3b_pkg::id_ex_t   id_ex_q;
    lc3b_pkg::ex_mem_t  ex_mem_d;
    lc3b_pkg::ex_mem_t  ex_mem_q;
    lc3b_pkg::mem_wb_t  mem_wb_d;
    lc3b_pkg::mem_wb_t  mem_wb_q;

    logic               stall_fetch;
    logic               stall_if_id;
    logic               stall_id_ex;
    logic               stall_ex_mem;
    logic               stall_mem_wb;
    logic               flush_if_id;
    logic               flush_id_ex;
    logic               flush_ex_mem;
    logic               flush_mem_wb;
    lc3b_pkg::fwd_sel_t fwd_a;
    lc3b_pkg::fwd_sel_t fwd_b;
    logic               mem_busy;
    logic               branch_taken;
    lc3b_pkg::lc3b_word branch_pc;

    // ##################################################
    // Fetch and decode.
    // ##################################################
    stage_fetch u_fetch (
        .clk,
        .arst_n,
        .stall       (stall_fetch),
        .redirect    (branch_taken),
        .redirect_pc (branch_pc),
        .imem_addr,
        .imem_rdata,
        .fetched
    );

    pipe_barrier #(.payload_t(lc3b_pkg::if_id_t)) u_if_id (
        .clk,
        .arst_n,
        .stall (stall_if_id),
        .flush (flush_if_id),
        .d     (fetched),
        .q     (if_id_q)
    );

    stage_decode u_decode (
        .clk,
        .arst_n,
        .in_if   (if_id_q),
        .wb      (mem_wb_q),
        .decoded
    );

    // A frozen ID/EX keeps reloading itself so it still sees the write that
    // retires from MEM/WB while the data access waits.
    always_comb begin
        id_ex_held = id_ex_q;
        if (mem_wb_q.valid && mem_wb_q.reg_write) begin
            if (mem_wb_q.dest == id_ex_q.sr1) begin
                id_ex_held.sr1_data = mem_wb_q.result;
            end
            if (mem_wb_q.dest == id_ex_q.sr2) begin
                id_ex_held.sr2_data = mem_wb_q.result;
            end
        end
        id_ex_d = stall_id_ex ? id_ex_held : decoded;
    end

    pipe_barrier #(.payload_t(lc3b_pkg::id_ex_t)) u_id_ex (
        .clk,
        .arst_n,
        .stall (1'b0),
        .flush (flush_id_ex),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    hazard_unit u_hazard (
        .in_id  (decoded),
        .in_ex  (id_ex_q),
        .in_mem (ex_mem_q),
        .in_wb  (mem_wb_q),
        .mem_busy,
        .branch_taken,
        .stall_fetch,
        .stall_if_id,
        .stall_id_ex,
        .stall_ex_mem,
        .stall_mem_wb,
        .flush_if_id,
        .flush_id_ex,
        .flush_ex_mem,
        .flush_mem_wb,
        .fwd_a,
        .fwd_b
    );

    // ##################################################
    // Execute, memory and writeback.
    // ##################################################
    stage_execute u_execute (
        .in_ex      (id_ex_q),
        .fwd_a,
        .fwd_b,
        .fwd_ex_mem (ex_mem_q.alu),
        .fwd_mem_wb (mem_wb_q.result),
        .out_ex     (ex_mem_d)
    );

    pipe_barrier #(.payload_t(lc3b_pkg::ex_mem_t)) u_ex_mem (
        .clk,
        .arst_n,
        .stall (stall_ex_mem),
        .flush (flush_ex_mem),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    stage_memory u_memory (
        .clk,
        .arst_n,
        .in_mem    (ex_mem_q),
        .dmem_req,
        .dmem_ack,
        .dmem_rdata,
        .busy      (mem_busy),
        .branch_taken,
        .branch_pc,
        .out_wb    (mem_wb_d)
    );

    pipe_barrier #(.payload_t(lc3b_pkg::mem_wb_t)) u_mem_wb (
        .clk,
        .arst_n,
        .stall (stall_mem_wb),
        .flush (flush_mem_wb),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    // One pulse per register write.
    assign retire.valid = mem_wb_q.valid & mem_wb_q.reg_write;
    assign retire.dest  = mem_wb_q.dest;
    assign retire.data  = mem_wb_q.result;

endmodule

`default_nettype wire

// ==== testbench/cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
    input  logic                clk,
    input  logic                arst_n,
    input  lc3b_pkg::retire_t   retire,
    input  lc3b_pkg::dmem_req_t dmem_req,
    input  logic                dmem_ack,
    input  lc3b_pkg::lc3b_word  patterns [256],
    output int                  error_count,
    output int                  retire_count,
    output int                  store_count,
    output logic                done
);

    localparam int RETIRE_BASE = 'h60;
    localparam int STORE_BASE  = 'ha0;

    int exp_retires;
    int exp_stores;

    assign exp_retires = int'(patterns[RETIRE_BASE]);
    assign exp_stores  = int'(patterns[STORE_BASE]);
    assign done        = (retire_count >= exp_retires) && (store_count >= exp_stores);

    task automatic compare(input string name, input lc3b_pkg::lc3b_word got,
                           input lc3b_pkg::lc3b_word expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            error_count++;
        end
    endtask

    // ##################################################
    // Sampled mid-cycle, when the DUT outputs have settled.
    // ##################################################
    always @(negedge clk) begin
        if (!arst_n) begin
            error_count  = 0;
            retire_count = 0;
            store_count  = 0;
        end else begin
            if (retire.valid) begin
                if (retire_count < exp_retires) begin
                    compare($sformatf("retire[%0d].dest", retire_count),
                            lc3b_pkg::lc3b_word'(retire.dest),
                            patterns[RETIRE_BASE + 1 + 2 * retire_count]);
                    compare($sformatf("retire[%0d].data", retire_count),
                            retire.data,
                            patterns[RETIRE_BASE + 2 + 2 * retire_count]);
                end else begin
                    $display("unexpected retire of r%0d = %h at %0t ns after the last write",
                             retire.dest, retire.data, $time);
                    error_count++;
                end
                retire_count++;
            end
            // A store completes in the cycle of its ack.
            if (dmem_req.req && dmem_req.we && dmem_ack) begin
                if (store_count < exp_stores) begin
                    compare($sformatf("store[%0d].addr", store_count),
                            dmem_req.addr,
                            patterns[STORE_BASE + 1 + 2 * store_count]);
                    compare($sformatf("store[%0d].wdata", store_count),
                            dmem_req.wdata,
                            patterns[STORE_BASE + 2 + 2 * store_count]);
                end else begin
                    $display("unexpected store of %h to %h at %0t ns after the last store",
                             dmem_req.wdata, dmem_req.addr, $time);
                    error_count++;
                end
                store_count++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam int DATA_BASE    = 'h40;
    localparam int DATA_WORDS   = 32;
    localparam int RETIRE_BASE  = 'h60;
    localparam int STORE_BASE   = 'ha0;
    localparam int DONE_LIMIT   = 2000;
    localparam int DRAIN_CYCLES = 20;

    logic                clk;
    logic                arst_n;
    lc3b_pkg::lc3b_word  imem_addr;
    lc3b_pkg::lc3b_word  imem_rdata;
    lc3b_pkg::dmem_req_t dmem_req;
    logic                dmem_ack;
    lc3b_pkg::lc3b_word  dmem_rdata;
    lc3b_pkg::retire_t   retire;

    lc3b_pkg::lc3b_word  patterns [256];
    lc3b_pkg::lc3b_word  data_mem [DATA_WORDS];
    integer              seed;
    logic                mem_pending;
    int                  mem_delay;
    int                  error_count;
    int                  retire_count;
    int                  store_count;
    logic                done;
    logic                timed_out;
    int                  cycles;

    cpu dut (
        .clk,
        .arst_n,
        .imem_addr,
        .imem_rdata,
        .dmem_req,
        .dmem_ack,
        .dmem_rdata,
        .retire
    );

    cpu_checker u_checker (
        .clk,
        .arst_n,
        .retire,
        .dmem_req,
        .dmem_ack,
        .patterns,
        .error_count,
        .retire_count,
        .store_count,
        .done
    );

    // Program image sits at the bottom of the pattern array.
    assign imem_rdata = patterns[imem_addr[6:1]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ##################################################
    // Data memory with 0 to 3 cycles of ack delay.
    // ##################################################
    always @(posedge clk) begin
        #1;
        dmem_ack = 1'b0;
        if (dmem_req.req && !mem_pending) begin
            mem_pending = 1'b1;
            mem_delay   = $random(seed) & 3;
        end
        if (mem_pending) begin
            if (mem_delay == 0) begin
                mem_pending = 1'b0;
                dmem_ack    = 1'b1;
                if (dmem_req.we) begin
                    data_mem[dmem_req.addr[5:1]] = dmem_req.wdata;
                end else begin
                    dmem_rdata = data_mem[dmem_req.addr[5:1]];
                end
            end else begin
                mem_delay = mem_delay - 1;
            end
        end
    end

    initial begin
        arst_n      = 1'b0;
        dmem_ack    = 1'b0;
        dmem_rdata  = '0;
        seed        = 32'hc128_ee1f;
        mem_pending = 1'b0;
        mem_delay   = 0;
        timed_out   = 1'b0;
        cycles      = 0;
        // Unlisted words read as a never-taken branch.
        for (int i = 0; i < 256; i++) begin
            patterns[i] = '0;
        end
        $readmemh("testbench/cpu_patterns.txt", patterns);
        for (int i = 0; i < DATA_WORDS; i++) begin
            data_mem[i] = patterns[DATA_BASE + i];
        end

        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        while (!done && cycles < DONE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            timed_out = 1'b1;
            $display("timeout: the program did not finish its writes within %0d cycles",
                     DONE_LIMIT);
        end else begin
            // The program ends in a branch to self, so nothing more may retire or store.
            repeat (DRAIN_CYCLES) @(posedge clk);
        end

        $display("retires %0d of %0d, stores %0d of %0d, errors %0d, timeouts %0d",
                 retire_count, patterns[RETIRE_BASE], store_count, patterns[STORE_BASE],
                 error_count, timed_out);
        if (timed_out || error_count != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
design/lc3b_pkg.sv
design/pipe_barrier.sv
design/stage_fetch.sv
design/stage_decode.sv
design/hazard_unit.sv
design/stage_execute.sv
design/stage_memory.sv
design/cpu.sv
testbench/cpu_checker.sv
testbench/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the CPU testbench, verdict taken from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_cpu -f build.f -o tb_cpu \
    && ./obj_dir/tb_cpu > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

// ==== testbench/cpu_patterns.txt ====
// One 16-bit hex word per entry. Sections: 00 program, 40 data memory,
// 60 retire count then dest/data pairs, a0 store count then addr/data pairs.
@00
5020 1227 147d 1642  // 00 and r0 #0, add r1 #7, add r2 #-3, add r3 r1 r2
58c1 9b3f 5b6e 1c28  // 08 and r4 r3 r1, not r5, and r5 #14, add r6 #8
1d86 6f80 11e1 7182  // 10 add r6 r6 r6, ldr r7, add r0 r7 #1, str r0 #2
6381 0802 14a1 16e1  // 18 ldr r1 #1, brn +2, two skipped adds
947f 0403 16b1 0201  // 20 not r2, brz +3, add r3 #-15, brp +1
0402 1921 7980 6982  // 28 brz +2, skipped add and str, ldr r4 #2
7983 1b01 6f83 7bb8  // 30 str r4 #3, add r5 r4 r1, ldr r7 #3, str r5 #-8
51c5 0fff            // 38 and r0 r7 r5, branch to self
// Data memory, word per two bytes.
@40
0101 0202 0303 0404 0505 0606 0707 0808
1234 fff0 7e7e 3c3c 0d0d 0e0e 0f0f 1010
1111 1212 1313 1414 1515 1616 1717 1818
1919 1a1a 1b1b 1c1c 1d1d 1e1e 1f1f 2020
// Register writes in program order.
@60
0012
0000 0000 0001 0007
0002 0004 0003 000b
0004 0003 0005 fffc
0005 000c 0006 0008
0006 0010 0007 1234
0000 1235 0001 fff0
0002 000f 0003 0000
0004 1235 0005 1225
0007 1235 0000 1225
// Stores in program order.
@a0
0003
0014 1235 0016 1235
0000 1225
